// File: verif/fpu_misc_trace.txt
# op single rs1 rs2 int_rs1 exp_result exp_int_result exp_fflags (all hex)
# op: 0 sgnj 1 sgnjn 2 sgnjx 3 min 4 max 5 feq 6 flt 7 fle 8 fclass 9 fmv.x a fmv.f
0 1 FFFFFFFF3F800000 FFFFFFFFC0000000 0000000000000000 FFFFFFFFBF800000 0000000000000000 00
1 1 FFFFFFFF3F800000 FFFFFFFFC0000000 0000000000000000 FFFFFFFF3F800000 0000000000000000 00
2 1 FFFFFFFFBF800000 FFFFFFFFC0000000 0000000000000000 FFFFFFFF3F800000 0000000000000000 00
0 0 3FF0000000000000 8000000000000000 0000000000000000 BFF0000000000000 0000000000000000 00
1 0 BFF0000000000000 4000000000000000 0000000000000000 BFF0000000000000 0000000000000000 00
2 0 BFF0000000000000 C000000000000000 0000000000000000 3FF0000000000000 0000000000000000 00
1 1 FFFFFFFF7FC00000 FFFFFFFF00000000 0000000000000000 FFFFFFFFFFC00000 0000000000000000 00
3 1 FFFFFFFF3F800000 FFFFFFFF40000000 0000000000000000 FFFFFFFF3F800000 0000000000000000 00
4 1 FFFFFFFF3F800000 FFFFFFFF40000000 0000000000000000 FFFFFFFF40000000 0000000000000000 00
3 1 FFFFFFFF00000000 FFFFFFFF80000000 0000000000000000 FFFFFFFF80000000 0000000000000000 00
4 1 FFFFFFFF00000000 FFFFFFFF80000000 0000000000000000 FFFFFFFF00000000 0000000000000000 00
3 0 8000000000000000 0000000000000000 0000000000000000 8000000000000000 0000000000000000 00
4 0 8000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000000 00
3 1 FFFFFFFF7FC00000 FFFFFFFFBF800000 0000000000000000 FFFFFFFFBF800000 0000000000000000 00
4 0 C000000000000000 7FF8000000000000 0000000000000000 C000000000000000 0000000000000000 00
3 1 FFFFFFFF7F800001 FFFFFFFF40000000 0000000000000000 FFFFFFFF40000000 0000000000000000 10
4 0 7FF8000000000000 7FF0000000000001 0000000000000000 7FF8000000000000 0000000000000000 10
3 1 FFFFFFFF7FC00001 FFFFFFFFFFC00000 0000000000000000 FFFFFFFF7FC00000 0000000000000000 00
4 1 FFFFFFFFC0000000 FFFFFFFFBF800000 0000000000000000 FFFFFFFFBF800000 0000000000000000 00
3 0 BFF0000000000000 C000000000000000 0000000000000000 C000000000000000 0000000000000000 00
5 1 FFFFFFFF3F800000 FFFFFFFF3F800000 0000000000000000 0000000000000000 0000000000000001 00
5 1 FFFFFFFF00000000 FFFFFFFF80000000 0000000000000000 0000000000000000 0000000000000001 00
6 1 FFFFFFFF80000000 FFFFFFFF00000000 0000000000000000 0000000000000000 0000000000000000 00
7 1 FFFFFFFF80000000 FFFFFFFF00000000 0000000000000000 0000000000000000 0000000000000001 00
6 0 3FF0000000000000 4000000000000000 0000000000000000 0000000000000000 0000000000000001 00
6 0 C000000000000000 BFF0000000000000 0000000000000000 0000000000000000 0000000000000001 00
7 0 4000000000000000 3FF0000000000000 0000000000000000 0000000000000000 0000000000000000 00
6 1 FFFFFFFFBF800000 FFFFFFFF3F800000 0000000000000000 0000000000000000 0000000000000001 00
5 0 7FF8000000000000 3FF0000000000000 0000000000000000 0000000000000000 0000000000000000 00
5 1 FFFFFFFF7F800001 FFFFFFFF3F800000 0000000000000000 0000000000000000 0000000000000000 10
6 1 FFFFFFFF3F800000 FFFFFFFF7FC00000 0000000000000000 0000000000000000 0000000000000000 10
7 0 7FF8000000000000 7FF8000000000000 0000000000000000 0000000000000000 0000000000000000 10
7 0 FFF0000000000000 7FF0000000000000 0000000000000000 0000000000000000 0000000000000001 00
5 0 4000000000000000 3FF0000000000000 0000000000000000 0000000000000000 0000000000000000 00
8 1 FFFFFFFFFF800000 0000000000000000 0000000000000000 0000000000000000 0000000000000001 00
8 1 FFFFFFFFBF800000 0000000000000000 0000000000000000 0000000000000000 0000000000000002 00
8 1 FFFFFFFF80000001 0000000000000000 0000000000000000 0000000000000000 0000000000000004 00
8 1 FFFFFFFF80000000 0000000000000000 0000000000000000 0000000000000000 0000000000000008 00
8 1 FFFFFFFF00000000 0000000000000000 0000000000000000 0000000000000000 0000000000000010 00
8 1 FFFFFFFF00000001 0000000000000000 0000000000000000 0000000000000000 0000000000000020 00
8 1 FFFFFFFF3F800000 0000000000000000 0000000000000000 0000000000000000 0000000000000040 00
8 1 FFFFFFFF7F800000 0000000000000000 0000000000000000 0000000000000000 0000000000000080 00
8 1 FFFFFFFF7F800001 0000000000000000 0000000000000000 0000000000000000 0000000000000100 00
8 1 FFFFFFFF7FC00000 0000000000000000 0000000000000000 0000000000000000 0000000000000200 00
8 0 FFF0000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000001 00
8 0 BFF0000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000002 00
8 0 8000000000000001 0000000000000000 0000000000000000 0000000000000000 0000000000000004 00
8 0 8000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000008 00
8 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000010 00
8 0 000FFFFFFFFFFFFF 0000000000000000 0000000000000000 0000000000000000 0000000000000020 00
8 0 3FF0000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000040 00
8 0 7FF0000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000080 00
8 0 7FF4000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000100 00
8 0 FFF8000000000000 0000000000000000 0000000000000000 0000000000000000 0000000000000200 00
9 1 FFFFFFFFBF800000 0000000000000000 0000000000000000 0000000000000000 FFFFFFFFBF800000 00
9 1 FFFFFFFF3F800000 0000000000000000 0000000000000000 0000000000000000 000000003F800000 00
9 0 C000000000000001 0000000000000000 0000000000000000 0000000000000000 C000000000000001 00
a 1 0000000000000000 0000000000000000 123456789ABCDEF0 FFFFFFFF9ABCDEF0 0000000000000000 00
a 0 0000000000000000 0000000000000000 0123456789ABCDEF 0123456789ABCDEF 0000000000000000 00

// File: build.f
+incdir+common
common/fpu_pkg.sv
src/fp_operand_decode.sv
src/fp_compare_unit.sv
src/fp_result_select.sv
src/fpu_misc_top.sv
verif/fpu_misc_tb.sv

// File: Makefile
# Verilator build and run of the FPU misc-op testbench

VERILATOR ?= verilator
TOP       ?= fpu_misc_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/fpu_misc_tb.sv
`timescale 1ns/1ps

module fpu_misc_tb;
    import fpu_pkg::*;

    localparam string TRACE_FILE   = "verif/fpu_misc_trace.txt";
    localparam int    RESP_TIMEOUT = 20;
    // Sampled at edge N, visible on the outputs after edge N+1
    localparam int    LATENCY_EDGES = 3;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    fpu_op_t  op;
    fp_reg_t  rs1;
    fp_reg_t  rs2;
    int_reg_t int_rs1;
    logic     is_single;
    logic     resp_valid;
    fp_reg_t  result;
    int_reg_t int_result;
    fflags_t  fflags;

    int       edge_count  = 0;
    int       error_count = 0;
    int       check_count = 0;

    // Expected response fields, one entry per request in flight
    fp_reg_t  exp_result_q[$];
    int_reg_t exp_int_q[$];
    fflags_t  exp_flags_q[$];
    int       exp_edge_q[$];

    fpu_misc_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .op         (op),
        .rs1        (rs1),
        .rs2        (rs2),
        .int_rs1    (int_rs1),
        .is_single  (is_single),
        .resp_valid (resp_valid),
        .result     (result),
        .int_result (int_result),
        .fflags     (fflags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // ====================================================================
    // Response monitor, outputs are stable at the falling edge
    // ====================================================================
    always @(negedge clk) begin
        if (!rst_n) begin
            if (resp_valid !== 1'b0) begin
                error_count++;
                $display("resp_valid is not low while reset is held at %0t ns", $time);
            end
        end else if (resp_valid === 1'b1) begin
            if (exp_result_q.size() == 0) begin
                error_count++;
                $display("A response came at %0t ns with no request outstanding", $time);
            end else begin
                compare_value("result", result, exp_result_q.pop_front());
                compare_value("int_result", int_result, exp_int_q.pop_front());
                compare_value("fflags", 64'(fflags), 64'(exp_flags_q.pop_front()));
                compare_value("response edge", 64'(edge_count), 64'(exp_edge_q.pop_front()));
            end
        end
    end

    // ====================================================================
    // Trace driven stimulus
    // ====================================================================
    initial begin
        string       line;
        int          fd;
        int          status;
        int          fields;
        int          waited;
        logic [3:0]  op_val;
        logic [3:0]  single_val;
        logic [63:0] rs1_val;
        logic [63:0] rs2_val;
        logic [63:0] int_val;
        logic [63:0] exp_res;
        logic [63:0] exp_int;
        logic [7:0]  exp_flags;

        rst_n     = 1'b0;
        req_valid = 1'b0;
        op        = FPU_SGNJ;
        is_single = 1'b0;
        rs1       = '0;
        rs2       = '0;
        int_rs1   = '0;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the trace file %s", TRACE_FILE);
        end else begin
            while (!$feof(fd)) begin
                status = $fgets(line, fd);
                // Skip comment lines starting with #
                if (status != 0 && line.len() > 0 && line.getc(0) != 8'h23) begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h", op_val, single_val,
                                     rs1_val, rs2_val, int_val, exp_res, exp_int, exp_flags);
                    if (fields == 8) begin
                        @(posedge clk);
                        req_valid <= 1'b1;
                        op        <= fpu_op_t'(op_val);
                        is_single <= single_val[0];
                        rs1       <= rs1_val;
                        rs2       <= rs2_val;
                        int_rs1   <= int_val;
                        exp_result_q.push_back(exp_res);
                        exp_int_q.push_back(exp_int);
                        exp_flags_q.push_back(fflags_t'(exp_flags));
                        exp_edge_q.push_back(edge_count + LATENCY_EDGES);
                    end
                end
            end
            $fclose(fd);
        end

        @(posedge clk);
        req_valid <= 1'b0;

        // Drain the pipeline
        waited = 0;
        while (exp_result_q.size() != 0 && waited < RESP_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_result_q.size() != 0) begin
            error_count++;
            $display("Timeout: %0d responses never arrived", exp_result_q.size());
        end

        // A few idle cycles to catch stray responses
        repeat (3) @(posedge clk);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: src/fpu_misc_top.sv
`timescale 1ns/1ps

module fpu_misc_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  fpu_pkg::fpu_op_t  op,
    input  fpu_pkg::fp_reg_t  rs1,
    input  fpu_pkg::fp_reg_t  rs2,
    input  fpu_pkg::int_reg_t int_rs1,
    input  logic              is_single,
    output logic              resp_valid,
    output fpu_pkg::fp_reg_t  result,
    output fpu_pkg::int_reg_t int_result,
    output fpu_pkg::fflags_t  fflags
);
    import fpu_pkg::*;

    // Decoded rs1
    logic    a_sign;
    fp_mag_t a_magnitude;
    logic    a_is_zero;
    logic    a_is_subnormal;
    logic    a_is_inf;
    logic    a_is_nan;
    logic    a_is_snan;

    // Decoded rs2
    logic    b_sign;
    fp_mag_t b_magnitude;
    logic    b_is_zero;
    logic    b_is_nan;
    logic    b_is_snan;

    // Compare results
    logic    equal;
    logic    less;
    logic    less_equal;
    logic    pick_a_min;
    logic    pick_a_max;
    logic    either_nan;
    logic    any_snan;

    // ====================================================================
    // Stage 1 operand decode
    // ====================================================================
    fp_operand_decode u_decode_a (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .operand      (rs1),
        .is_single    (is_single),
        .sign         (a_sign),
        .magnitude    (a_magnitude),
        .is_zero      (a_is_zero),
        .is_subnormal (a_is_subnormal),
        .is_inf       (a_is_inf),
        .is_nan       (a_is_nan),
        .is_snan      (a_is_snan)
    );

    // FCLASS looks at rs1 only
    fp_operand_decode u_decode_b (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .operand      (rs2),
        .is_single    (is_single),
        .sign         (b_sign),
        .magnitude    (b_magnitude),
        .is_zero      (b_is_zero),
        .is_subnormal (),
        .is_inf       (),
        .is_nan       (b_is_nan),
        .is_snan      (b_is_snan)
    );

    fp_compare_unit u_compare (
        .a_sign      (a_sign),
        .a_magnitude (a_magnitude),
        .a_is_zero   (a_is_zero),
        .a_is_nan    (a_is_nan),
        .a_is_snan   (a_is_snan),
        .b_sign      (b_sign),
        .b_magnitude (b_magnitude),
        .b_is_zero   (b_is_zero),
        .b_is_nan    (b_is_nan),
        .b_is_snan   (b_is_snan),
        .equal       (equal),
        .less        (less),
        .less_equal  (less_equal),
        .pick_a_min  (pick_a_min),
        .pick_a_max  (pick_a_max),
        .either_nan  (either_nan),
        .any_snan    (any_snan)
    );

    // ====================================================================
    // Stage 2 result build and output registers
    // ====================================================================
    fp_result_select u_select (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .op             (op),
        .is_single      (is_single),
        .rs1            (rs1),
        .rs2            (rs2),
        .int_rs1        (int_rs1),
        .a_sign         (a_sign),
        .a_is_zero      (a_is_zero),
        .a_is_subnormal (a_is_subnormal),
        .a_is_inf       (a_is_inf),
        .a_is_nan       (a_is_nan),
        .a_is_snan      (a_is_snan),
        .b_is_nan       (b_is_nan),
        .equal          (equal),
        .less           (less),
        .less_equal     (less_equal),
        .pick_a_min     (pick_a_min),
        .pick_a_max     (pick_a_max),
        .either_nan     (either_nan),
        .any_snan       (any_snan),
        .resp_valid     (resp_valid),
        .result         (result),
        .int_result     (int_result),
        .fflags         (fflags)
    );

endmodule

// File: src/fp_result_select.sv
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fp_result_select (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  fpu_pkg::fpu_op_t  op,
    input  logic              is_single,
    input  fpu_pkg::fp_reg_t  rs1,
    input  fpu_pkg::fp_reg_t  rs2,
    input  fpu_pkg::int_reg_t int_rs1,
    input  logic              a_sign,
    input  logic              a_is_zero,
    input  logic              a_is_subnormal,
    input  logic              a_is_inf,
    input  logic              a_is_nan,
    input  logic              a_is_snan,
    input  logic              b_is_nan,
    input  logic              equal,
    input  logic              less,
    input  logic              less_equal,
    input  logic              pick_a_min,
    input  logic              pick_a_max,
    input  logic              either_nan,
    input  logic              any_snan,
    output logic              resp_valid,
    output fpu_pkg::fp_reg_t  result,
    output fpu_pkg::int_reg_t int_result,
    output fpu_pkg::fflags_t  fflags
);
    import fpu_pkg::*;

    // Stage 1
    logic        valid_q;
    fpu_op_t     op_q;
    logic        single_q;
    fp_reg_t     rs1_q;
    fp_reg_t     rs2_q;
    int_reg_t    int_rs1_q;

    // Stage 2 inputs
    fp_reg_t     sgnj_value;
    fp_reg_t     minmax_value;
    fp_reg_t     canon_nan;
    logic        is_normal;
    class_mask_t class_mask;
    fp_reg_t     result_d;
    int_reg_t    int_result_d;
    fflags_t     fflags_d;

    function automatic fp_reg_t nan_box(input logic [31:0] value);
        return {`FPU_BOX, value};
    endfunction

    // ====================================================================
    // Stage 1 registers
    // ====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            op_q     <= FPU_SGNJ;
            single_q <= 1'b0;
        end else begin
            valid_q <= req_valid;
            if (req_valid) begin
                op_q     <= op;
                single_q <= is_single;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rs1_q     <= rs1;
            rs2_q     <= rs2;
            int_rs1_q <= int_rs1;
        end
    end

    // ====================================================================
    // Per-op results
    // ====================================================================
    always_comb begin
        logic s1;
        logic s2;
        logic inj_sign;
        s1 = single_q ? rs1_q[`FPU_SP_SIGN] : rs1_q[`FPU_DP_SIGN];
        s2 = single_q ? rs2_q[`FPU_SP_SIGN] : rs2_q[`FPU_DP_SIGN];
        case (op_q)
            FPU_SGNJN: inj_sign = ~s2;
            FPU_SGNJX: inj_sign = s1 ^ s2;
            default:   inj_sign = s2;
        endcase
        if (single_q) begin
            sgnj_value = nan_box({inj_sign, rs1_q[`FPU_SP_SIGN-1:0]});
        end else begin
            sgnj_value = {inj_sign, rs1_q[`FPU_DP_SIGN-1:0]};
        end
    end

    assign canon_nan = single_q ? nan_box(`FPU_SP_QNAN) : `FPU_DP_QNAN;

    always_comb begin
        logic take_a;
        take_a = (op_q == FPU_MIN) ? pick_a_min : pick_a_max;
        if (a_is_nan && b_is_nan) begin
            minmax_value = canon_nan;
        end else if (take_a) begin
            minmax_value = single_q ? nan_box(rs1_q[`FPU_SP_SIGN:0]) : rs1_q;
        end else begin
            minmax_value = single_q ? nan_box(rs2_q[`FPU_SP_SIGN:0]) : rs2_q;
        end
    end

    // FCLASS bit 0 is -inf, bit 9 is quiet NaN
    assign is_normal  = !(a_is_zero || a_is_subnormal || a_is_inf || a_is_nan);
    assign class_mask = {a_is_nan && !a_is_snan,
                         a_is_snan,
                         a_is_inf && !a_sign,
                         is_normal && !a_sign,
                         a_is_subnormal && !a_sign,
                         a_is_zero && !a_sign,
                         a_is_zero && a_sign,
                         a_is_subnormal && a_sign,
                         is_normal && a_sign,
                         a_is_inf && a_sign};

    // ====================================================================
    // Result mux
    // ====================================================================
    always_comb begin
        result_d     = '0;
        int_result_d = '0;
        fflags_d     = '0;
        case (op_q)
            FPU_SGNJ, FPU_SGNJN, FPU_SGNJX: begin
                result_d = sgnj_value;
            end
            FPU_MIN, FPU_MAX: begin
                result_d              = minmax_value;
                fflags_d[`FPU_FLAG_NV] = any_snan;
            end
            FPU_CMP_EQ: begin
                int_result_d           = int_reg_t'(equal);
                fflags_d[`FPU_FLAG_NV] = any_snan;
            end
            FPU_CMP_LT: begin
                int_result_d           = int_reg_t'(less);
                fflags_d[`FPU_FLAG_NV] = either_nan;
            end
            FPU_CMP_LE: begin
                int_result_d           = int_reg_t'(less_equal);
                fflags_d[`FPU_FLAG_NV] = either_nan;
            end
            FPU_CLASS: begin
                int_result_d = int_reg_t'(class_mask);
            end
            FPU_MV_X_W: begin
                int_result_d = single_q ? {{32{rs1_q[`FPU_SP_SIGN]}}, rs1_q[`FPU_SP_SIGN:0]}
                                        : rs1_q;
            end
            FPU_MV_W_X: begin
                result_d = single_q ? nan_box(int_rs1_q[31:0]) : int_rs1_q;
            end
            default: ;
        endcase
    end

    // Stage 2 output registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            result     <= '0;
            int_result <= '0;
            fflags     <= '0;
        end else begin
            resp_valid <= valid_q;
            if (valid_q) begin
                result     <= result_d;
                int_result <= int_result_d;
                fflags     <= fflags_d;
            end
        end
    end

    // Every accepted request answers two edges later
    a_fixed_latency : assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> ##2 resp_valid)
        else $error("response missing two cycles after request");

    // Only NV can be raised by these ops
    a_only_nv : assert property (@(posedge clk) disable iff (!rst_n)
        fflags[`FPU_FLAG_NV-1:0] == '0)
        else $error("flag other than NV raised");

endmodule

// File: src/fp_compare_unit.sv
`timescale 1ns/1ps

module fp_compare_unit (
    input  logic             a_sign,
    input  fpu_pkg::fp_mag_t a_magnitude,
    input  logic             a_is_zero,
    input  logic             a_is_nan,
    input  logic             a_is_snan,
    input  logic             b_sign,
    input  fpu_pkg::fp_mag_t b_magnitude,
    input  logic             b_is_zero,
    input  logic             b_is_nan,
    input  logic             b_is_snan,
    output logic             equal,
    output logic             less,
    output logic             less_equal,
    output logic             pick_a_min,
    output logic             pick_a_max,
    output logic             either_nan,
    output logic             any_snan
);

    logic mag_equal;
    logic mag_less;
    logic same_sign;
    logic both_zero;
    logic ord_equal;
    logic ord_less;
    logic tot_equal;
    logic tot_less;

    // Sign-magnitude encoding orders like an unsigned integer
    assign mag_equal = a_magnitude == b_magnitude;
    assign mag_less  = a_magnitude < b_magnitude;
    assign same_sign = a_sign == b_sign;
    assign both_zero = a_is_zero && b_is_zero;

    // ====================================================================
    // Numeric order, +0 and -0 are equal
    // ====================================================================
    assign ord_equal = both_zero || (same_sign && mag_equal);

    always_comb begin
        if (both_zero) begin
            ord_less = 1'b0;
        end else if (!same_sign) begin
            ord_less = a_sign;
        end else if (a_sign) begin
            // Both negative, larger magnitude is smaller
            ord_less = !mag_less && !mag_equal;
        end else begin
            ord_less = mag_less;
        end
    end

    assign either_nan = a_is_nan || b_is_nan;
    assign any_snan   = a_is_snan || b_is_snan;

    // Unordered operands compare false
    assign equal      = !either_nan && ord_equal;
    assign less       = !either_nan && ord_less;
    assign less_equal = !either_nan && (ord_less || ord_equal);

    // ====================================================================
    // Total order for FMIN/FMAX, -0 sits below +0
    // ====================================================================
    assign tot_equal = same_sign && mag_equal;
    assign tot_less  = same_sign ? (a_sign ? (!mag_less && !mag_equal) : mag_less)
                                 : a_sign;

    // A NaN operand loses, ties keep a
    always_comb begin
        if (b_is_nan) begin
            pick_a_min = 1'b1;
            pick_a_max = 1'b1;
        end else if (a_is_nan) begin
            pick_a_min = 1'b0;
            pick_a_max = 1'b0;
        end else begin
            pick_a_min = tot_less || tot_equal;
            pick_a_max = !tot_less;
        end
    end

endmodule

// File: src/fp_operand_decode.sv
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fp_operand_decode (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    input  fpu_pkg::fp_reg_t operand,
    input  logic             is_single,
    output logic             sign,
    output fpu_pkg::fp_mag_t magnitude,
    output logic             is_zero,
    output logic             is_subnormal,
    output logic             is_inf,
    output logic             is_nan,
    output logic             is_snan
);
    import fpu_pkg::*;

    fp_reg_t operand_q;
    logic    single_q;

    logic    exp_all_zero;
    logic    exp_all_ones;
    logic    frac_zero;
    logic    quiet_bit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            operand_q <= '0;
            single_q  <= 1'b0;
        end else if (req_valid) begin
            operand_q <= operand;
            single_q  <= is_single;
        end
    end

    // ====================================================================
    // Field extraction for the registered format
    // ====================================================================
    always_comb begin
        if (single_q) begin
            sign         = operand_q[`FPU_SP_SIGN];
            magnitude    = fp_mag_t'(operand_q[`FPU_SP_SIGN-1:0]);
            exp_all_zero = operand_q[`FPU_SP_SIGN-1 -: `FPU_SP_EXP_W] == '0;
            exp_all_ones = operand_q[`FPU_SP_SIGN-1 -: `FPU_SP_EXP_W] == `FPU_SP_EXP_MAX;
            frac_zero    = operand_q[`FPU_SP_FRAC_W-1:0] == '0;
            quiet_bit    = operand_q[`FPU_SP_FRAC_W-1];
        end else begin
            sign         = operand_q[`FPU_DP_SIGN];
            magnitude    = operand_q[`FPU_DP_SIGN-1:0];
            exp_all_zero = operand_q[`FPU_DP_SIGN-1 -: `FPU_DP_EXP_W] == '0;
            exp_all_ones = operand_q[`FPU_DP_SIGN-1 -: `FPU_DP_EXP_W] == `FPU_DP_EXP_MAX;
            frac_zero    = operand_q[`FPU_DP_FRAC_W-1:0] == '0;
            quiet_bit    = operand_q[`FPU_DP_FRAC_W-1];
        end
    end

    // Class flags
    assign is_zero      = exp_all_zero && frac_zero;
    assign is_subnormal = exp_all_zero && !frac_zero;
    assign is_inf       = exp_all_ones && frac_zero;
    assign is_nan       = exp_all_ones && !frac_zero;
    // Quiet bit clear means signalling
    assign is_snan      = is_nan && !quiet_bit;

    // Zero class and magnitude come from separate field slices
    a_zero_magnitude : assert property (@(posedge clk) disable iff (!rst_n)
        is_zero == (magnitude == '0))
        else $error("zero class disagrees with the operand magnitude");

endmodule

// File: common/fpu_pkg.sv
`include "fpu_settings.svh"

package fpu_pkg;

    // ====================================================================
    // Data types
    // ====================================================================

    // Floating register contents, binary32 is NaN-boxed
    typedef logic [`FPU_FLEN-1:0] fp_reg_t;

    // Integer source and destination
    typedef logic [`FPU_XLEN-1:0] int_reg_t;

    // Magnitude without the sign, binary32 zero-extended
    typedef logic [`FPU_FLEN-2:0] fp_mag_t;

    // Flags from MSB down: NV DZ OF UF NX
    typedef logic [`FPU_FLAGS_W-1:0] fflags_t;

    // One bit per FCLASS category
    typedef logic [`FPU_CLASS_W-1:0] class_mask_t;

    // ====================================================================
    // Operations
    // ====================================================================

    typedef enum logic [3:0] {
        FPU_SGNJ   = 4'd0,
        FPU_SGNJN  = 4'd1,
        FPU_SGNJX  = 4'd2,
        FPU_MIN    = 4'd3,
        FPU_MAX    = 4'd4,
        FPU_CMP_EQ = 4'd5,
        FPU_CMP_LT = 4'd6,
        FPU_CMP_LE = 4'd7,
        FPU_CLASS  = 4'd8,
        FPU_MV_X_W = 4'd9,
        FPU_MV_W_X = 4'd10
    } fpu_op_t;

endpackage

// File: common/fpu_settings.svh
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// ====================================================================
// Register and result widths
// ====================================================================
`define FPU_FLEN        64
`define FPU_XLEN        64
`define FPU_FLAGS_W     5
`define FPU_CLASS_W     10

// ====================================================================
// Field layout of binary32 and binary64
// ====================================================================
`define FPU_SP_SIGN     31
`define FPU_SP_EXP_W    8
`define FPU_SP_FRAC_W   23
`define FPU_SP_EXP_MAX  8'hFF

`define FPU_DP_SIGN     63
`define FPU_DP_EXP_W    11
`define FPU_DP_FRAC_W   52
`define FPU_DP_EXP_MAX  11'h7FF

// Canonical quiet NaNs
`define FPU_SP_QNAN     32'h7FC0_0000
`define FPU_DP_QNAN     64'h7FF8_0000_0000_0000

// Upper half of a NaN-boxed binary32 value
`define FPU_BOX         32'hFFFF_FFFF

// NV is the top bit of fflags
`define FPU_FLAG_NV     4

`endif
